//--- rtl/win_screen_macros.svh
// ########################################
// Geometry and palette of the win screen
// Include in any file that places or colours the king
// ########################################
`ifndef WIN_SCREEN_MACROS_SVH
`define WIN_SCREEN_MACROS_SVH

// Edge of one grid cell in pixels
`define KING_CELL 24

// Top left corner of the king grid
`define KING_X0 272
`define KING_Y0 116

// Grid size in cells
`define KING_COLS 20
`define KING_ROWS 23

// Outline colour, shared by both schemes
`define COLOR_BORDER 12'h666

// White king on a light background
`define COLOR_WHITE_FILL 12'hfff
`define COLOR_WHITE_BG 12'heee

// Black king on a dark background
`define COLOR_BLACK_FILL 12'h000
`define COLOR_BLACK_BG 12'h111

`endif

//--- rtl/vga_pkg.sv
// ########################################
// Types shared by the VGA pipeline stages
// Referenced by scoped names, never imported
// ########################################
`default_nettype none

package vga_pkg;

        // 4 bits per channel, red in the top nibble
        typedef logic [11:0] rgb_t;

        // Timing and colour of one pixel
        typedef struct packed {
                logic [10:0] hcount;
                logic [10:0] vcount;
                logic        hsync;
                logic        vsync;
                logic        hblnk;
                logic        vblnk;
                rgb_t        rgb;
        } vga_bus_t;

        // What the king shape holds at one grid cell
        typedef enum logic [1:0] {
                CELL_NONE   = 2'd0,
                CELL_BORDER = 2'd1,
                CELL_FILL   = 2'd2
        } cell_class_t;

endpackage

`default_nettype wire

//--- rtl/king_cell_locator.sv
// ########################################
// First pipeline stage of the win screen
// Maps each pixel to its king grid cell
// ########################################
`default_nettype none

`include "win_screen_macros.svh"

module king_cell_locator (
        input  logic              clk,
        input  logic              rst,
        input  vga_pkg::vga_bus_t vga_in,
        input  logic              white_win,
        input  logic              black_win,
        output vga_pkg::vga_bus_t vga_s1,
        output logic              white_s1,
        output logic              black_s1,
        output logic              in_grid,
        output logic [4:0]        col,
        output logic [4:0]        row
);

        logic [10:0] x_off;
        logic [10:0] y_off;
        logic [4:0]  col_nxt;
        logic [4:0]  row_nxt;
        logic        in_grid_nxt;

        // Offsets wrap outside the grid, in_grid masks those cases
        always_comb begin
                x_off = vga_in.hcount - 11'(`KING_X0);
                y_off = vga_in.vcount - 11'(`KING_Y0);

                col_nxt = 5'(x_off / 11'(`KING_CELL));
                row_nxt = 5'(y_off / 11'(`KING_CELL));

                in_grid_nxt = (vga_in.hcount >= `KING_X0) &&
                              (vga_in.hcount < `KING_X0 + `KING_COLS * `KING_CELL) &&
                              (vga_in.vcount >= `KING_Y0) &&
                              (vga_in.vcount < `KING_Y0 + `KING_ROWS * `KING_CELL);
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        vga_s1   <= '0;
                        white_s1 <= 1'b0;
                        black_s1 <= 1'b0;
                        in_grid  <= 1'b0;
                        col      <= '0;
                        row      <= '0;
                end else begin
                        vga_s1   <= vga_in;
                        white_s1 <= white_win;
                        black_s1 <= black_win;
                        in_grid  <= in_grid_nxt;
                        col      <= col_nxt;
                        row      <= row_nxt;
                end
        end

        // Shape table only covers the grid, so an in-grid cell must index it
        cell_in_table: assert property (
                @(posedge clk) disable iff (rst)
                in_grid |-> (col < `KING_COLS) && (row < `KING_ROWS)
        );

endmodule

`default_nettype wire

//--- rtl/king_shape_rom.sv
// ########################################
// King outline on a 20 x 23 cell grid
// Shared by the white and black win screens
// ########################################
`default_nettype none

module king_shape_rom (
        input  logic [4:0]           row,
        input  logic [4:0]           col,
        output vga_pkg::cell_class_t cell_class
);

        logic is_border;
        logic is_fill;

        function automatic logic span(input logic [4:0] c,
                                      input logic [4:0] lo,
                                      input logic [4:0] hi);
                return (c >= lo) && (c <= hi);
        endfunction

        // Row 0 is the top of the cross
        always_comb begin
                is_border = 1'b0;
                is_fill   = 1'b0;
                case (row)
                        5'd0: begin
                                is_border = span(col, 5'd9, 5'd10);
                        end
                        5'd1: begin
                                is_border = (col == 5'd8) || (col == 5'd11);
                                is_fill   = span(col, 5'd9, 5'd10);
                        end
                        5'd2, 5'd5: begin
                                is_border = span(col, 5'd7, 5'd8) || span(col, 5'd11, 5'd12);
                                is_fill   = span(col, 5'd9, 5'd10);
                        end
                        // Cross bar
                        5'd3, 5'd4: begin
                                is_border = (col == 5'd6) || (col == 5'd13);
                                is_fill   = span(col, 5'd7, 5'd12);
                        end
                        // Shoulders start growing out of the stem
                        5'd6: begin
                                is_border = span(col, 5'd2, 5'd5) || span(col, 5'd7, 5'd8) ||
                                            span(col, 5'd11, 5'd12) || span(col, 5'd14, 5'd17);
                                is_fill   = span(col, 5'd9, 5'd10);
                        end
                        5'd7: begin
                                is_border = (col == 5'd1) || span(col, 5'd6, 5'd8) ||
                                            span(col, 5'd11, 5'd13) || (col == 5'd18);
                                is_fill   = span(col, 5'd2, 5'd5) || span(col, 5'd9, 5'd10) ||
                                            span(col, 5'd14, 5'd17);
                        end
                        5'd8: begin
                                is_border = (col == 5'd0) || (col == 5'd8) ||
                                            (col == 5'd11) || (col == 5'd19);
                                is_fill   = span(col, 5'd1, 5'd7) || span(col, 5'd9, 5'd10) ||
                                            span(col, 5'd12, 5'd18);
                        end
                        5'd9, 5'd10: begin
                                is_border = (col == 5'd0) || span(col, 5'd9, 5'd10) ||
                                            (col == 5'd19);
                                is_fill   = span(col, 5'd1, 5'd8) || span(col, 5'd11, 5'd18);
                        end
                        // Widest part of the body
                        5'd11, 5'd12, 5'd13, 5'd14: begin
                                is_border = (col == 5'd0) || (col == 5'd19);
                                is_fill   = span(col, 5'd1, 5'd18);
                        end
                        5'd15, 5'd16: begin
                                is_border = (col == 5'd1) || (col == 5'd18);
                                is_fill   = span(col, 5'd2, 5'd17);
                        end
                        5'd17, 5'd21: begin
                                is_border = (col == 5'd2) || (col == 5'd17);
                                is_fill   = span(col, 5'd3, 5'd16);
                        end
                        5'd18: begin
                                is_border = span(col, 5'd3, 5'd16);
                        end
                        5'd19: begin
                                is_border = (col == 5'd3) || (col == 5'd16);
                                is_fill   = span(col, 5'd4, 5'd15);
                        end
                        // Base plate outlines
                        5'd20, 5'd22: begin
                                is_border = span(col, 5'd2, 5'd17);
                        end
                        default: begin
                                is_border = 1'b0;
                                is_fill   = 1'b0;
                        end
                endcase

                if (is_border) begin
                        cell_class = vga_pkg::CELL_BORDER;
                end else if (is_fill) begin
                        cell_class = vga_pkg::CELL_FILL;
                end else begin
                        cell_class = vga_pkg::CELL_NONE;
                end
        end

endmodule

`default_nettype wire

//--- rtl/win_colorizer.sv
// ########################################
// Second pipeline stage of the win screen
// Paints the winner's scheme or passes the pixel
// ########################################
`default_nettype none

`include "win_screen_macros.svh"

module win_colorizer (
        input  logic                 clk,
        input  logic                 rst,
        input  vga_pkg::vga_bus_t    vga_s1,
        input  logic                 white_s1,
        input  logic                 black_s1,
        input  logic                 in_grid,
        input  vga_pkg::cell_class_t cell_class,
        output vga_pkg::vga_bus_t    vga_out
);

        vga_pkg::cell_class_t cls;
        vga_pkg::vga_bus_t    vga_nxt;

        always_comb begin
                // Outside the grid everything is background
                cls = in_grid ? cell_class : vga_pkg::CELL_NONE;

                // Timing fields go through untouched
                vga_nxt = vga_s1;

                // White wins a tie
                if (white_s1) begin
                        case (cls)
                                vga_pkg::CELL_BORDER: vga_nxt.rgb = `COLOR_BORDER;
                                vga_pkg::CELL_FILL:   vga_nxt.rgb = `COLOR_WHITE_FILL;
                                default:              vga_nxt.rgb = `COLOR_WHITE_BG;
                        endcase
                end else if (black_s1) begin
                        case (cls)
                                vga_pkg::CELL_BORDER: vga_nxt.rgb = `COLOR_BORDER;
                                vga_pkg::CELL_FILL:   vga_nxt.rgb = `COLOR_BLACK_FILL;
                                default:              vga_nxt.rgb = `COLOR_BLACK_BG;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        vga_out <= '0;
                end else begin
                        vga_out <= vga_nxt;
                end
        end

        // During play the board image must come through unaltered
        pass_through_rgb: assert property (
                @(posedge clk) disable iff (rst)
                (!white_s1 && !black_s1) |=> (vga_out.rgb == $past(vga_s1.rgb))
        );

endmodule

`default_nettype wire

//--- rtl/draw_win.sv
// ########################################
// Win screen overlay for the chess display
// Two cycle pipeline, drop in on the VGA path
// ########################################
`default_nettype none

module draw_win (
        input  logic              clk,
        input  logic              rst,
        input  vga_pkg::vga_bus_t vga_in,
        input  logic              white_win,
        input  logic              black_win,
        output vga_pkg::vga_bus_t vga_out
);

        vga_pkg::vga_bus_t    vga_s1;
        logic                 white_s1;
        logic                 black_s1;
        logic                 in_grid;
        logic [4:0]           col;
        logic [4:0]           row;
        vga_pkg::cell_class_t cell_class;

        king_cell_locator u_locator (
                .clk       (clk),
                .rst       (rst),
                .vga_in    (vga_in),
                .white_win (white_win),
                .black_win (black_win),
                .vga_s1    (vga_s1),
                .white_s1  (white_s1),
                .black_s1  (black_s1),
                .in_grid   (in_grid),
                .col       (col),
                .row       (row)
        );

        // Combinational, sits between the two register stages
        king_shape_rom u_shape (
                .row        (row),
                .col        (col),
                .cell_class (cell_class)
        );

        win_colorizer u_colorizer (
                .clk        (clk),
                .rst        (rst),
                .vga_s1     (vga_s1),
                .white_s1   (white_s1),
                .black_s1   (black_s1),
                .in_grid    (in_grid),
                .cell_class (cell_class),
                .vga_out    (vga_out)
        );

endmodule

`default_nettype wire

//--- verification/tb_draw_win.sv
// ########################################
// Testbench for the win screen overlay
// Runs a stimulus table through the DUT
// ########################################
`default_nettype none

`include "win_screen_macros.svh"

module tb_draw_win;

        timeunit 1ns;
        timeprecision 100ps;

        localparam int          CLK_PERIOD = 4;
        localparam logic [31:0] LFSR_SEED  = 32'he0f96b69;

        // One table row with pixel, flags and expected colour
        typedef struct packed {
                vga_pkg::vga_bus_t bus;
                logic              white;
                logic              black;
                logic [11:0]       exp_rgb;
        } stim_t;

        logic              clk;
        logic              rst;
        vga_pkg::vga_bus_t vga_in;
        logic              white_win;
        logic              black_win;
        vga_pkg::vga_bus_t vga_out;

        stim_t             stim_table[$];
        vga_pkg::vga_bus_t exp_q[$];
        int                table_len = 0;
        logic [31:0]       lfsr_state;
        string             shape [0:22];

        draw_win uut (
                .clk       (clk),
                .rst       (rst),
                .vga_in    (vga_in),
                .white_win (white_win),
                .black_win (black_win),
                .vga_out   (vga_out)
        );

        always #(CLK_PERIOD / 2) clk = ~clk;

        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
        endfunction

        // One LFSR step per bit handed out
        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] r;
                int          k;
                r = '0;
                for (k = 0; k < n; k++) begin
                        r = {r[30:0], lfsr_state[0]};
                        lfsr_state = lfsr_next(lfsr_state);
                end
                return r;
        endfunction

        // King drawing with column 0 on the left
        // B marks border cells, F fill cells and a dot empty ones
        task automatic load_shape();
                shape[0]  = ".........BB.........";
                shape[1]  = "........BFFB........";
                shape[2]  = ".......BBFFBB.......";
                shape[3]  = "......BFFFFFFB......";
                shape[4]  = "......BFFFFFFB......";
                shape[5]  = ".......BBFFBB.......";
                shape[6]  = "..BBBB.BBFFBB.BBBB..";
                shape[7]  = ".BFFFFBBBFFBBBFFFFB.";
                shape[8]  = "BFFFFFFFBFFBFFFFFFFB";
                shape[9]  = "BFFFFFFFFBBFFFFFFFFB";
                shape[10] = "BFFFFFFFFBBFFFFFFFFB";
                shape[11] = "BFFFFFFFFFFFFFFFFFFB";
                shape[12] = "BFFFFFFFFFFFFFFFFFFB";
                shape[13] = "BFFFFFFFFFFFFFFFFFFB";
                shape[14] = "BFFFFFFFFFFFFFFFFFFB";
                shape[15] = ".BFFFFFFFFFFFFFFFFB.";
                shape[16] = ".BFFFFFFFFFFFFFFFFB.";
                shape[17] = "..BFFFFFFFFFFFFFFB..";
                shape[18] = "...BBBBBBBBBBBBBB...";
                shape[19] = "...BFFFFFFFFFFFFB...";
                shape[20] = "..BBBBBBBBBBBBBBBB..";
                shape[21] = "..BFFFFFFFFFFFFFFB..";
                shape[22] = "..BBBBBBBBBBBBBBBB..";
        endtask

        // Reference colour for one pixel
        function automatic logic [11:0] ref_rgb(input vga_pkg::vga_bus_t px,
                                                input logic white,
                                                input logic black);
                int    h;
                int    v;
                byte   ch;
                string line;
                h  = px.hcount;
                v  = px.vcount;
                ch = ".";
                if (h >= 272 && h < 752 && v >= 116 && v < 668) begin
                        line = shape[(v - 116) / 24];
                        ch   = line.getc((h - 272) / 24);
                end
                if (!white && !black) begin
                        return px.rgb;
                end
                if (ch == "B") begin
                        return `COLOR_BORDER;
                end
                if (white) begin
                        return (ch == "F") ? `COLOR_WHITE_FILL : `COLOR_WHITE_BG;
                end
                return (ch == "F") ? `COLOR_BLACK_FILL : `COLOR_BLACK_BG;
        endfunction

        task automatic add_entry(input logic [10:0] h, input logic [10:0] v,
                                 input logic white, input logic black);
                stim_t e;
                e.bus.hcount = h;
                e.bus.vcount = v;
                e.bus.hsync  = 1'(rand_bits(1));
                e.bus.vsync  = 1'(rand_bits(1));
                e.bus.hblnk  = 1'(rand_bits(1));
                e.bus.vblnk  = 1'(rand_bits(1));
                e.bus.rgb    = 12'(rand_bits(12));
                e.white      = white;
                e.black      = black;
                e.exp_rgb    = ref_rgb(e.bus, white, black);
                stim_table.push_back(e);
        endtask

        // Border, fill and background probes including the grid edges
        task automatic add_probe_set(input logic white, input logic black);
                add_entry(11'd488, 11'd116, white, black);
                add_entry(11'd488, 11'd115, white, black);
                add_entry(11'd280, 11'd120, white, black);
                add_entry(11'd397, 11'd390, white, black);
                add_entry(11'd271, 11'd380, white, black);
                add_entry(11'd272, 11'd380, white, black);
                add_entry(11'd751, 11'd380, white, black);
                add_entry(11'd752, 11'd380, white, black);
                add_entry(11'd392, 11'd667, white, black);
                add_entry(11'd392, 11'd668, white, black);
                add_entry(11'd439, 11'd188, white, black);
                add_entry(11'd440, 11'd188, white, black);
                add_entry(11'd500, 11'd571, white, black);
                add_entry(11'd500, 11'd595, white, black);
        endtask

        task automatic build_table();
                int i;
                // Normal play anywhere on the screen
                for (i = 0; i < 16; i++) begin
                        add_entry(11'(rand_bits(11)), 11'(rand_bits(11)), 1'b0, 1'b0);
                end
                add_probe_set(1'b1, 1'b0);
                add_probe_set(1'b0, 1'b1);
                add_probe_set(1'b1, 1'b1);
                // Flags toggle every cycle through white, black, none and both
                for (i = 0; i < 16; i++) begin
                        add_entry((i < 8) ? 11'd397 : 11'd280, (i < 8) ? 11'd390 : 11'd120,
                                  (i % 4 == 0) || (i % 4 == 3), (i % 4 == 1) || (i % 4 == 3));
                end
        endtask

        task automatic check_value(input string name, input logic [38:0] got,
                                   input logic [38:0] want);
                if (got !== want) begin
                        $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, want);
                        $display("TEST FAILED");
                        $fatal(1, "output mismatch");
                end
        endtask

        task automatic expect_output(input vga_pkg::vga_bus_t want);
                check_value("vga_out.hcount", vga_out.hcount, want.hcount);
                check_value("vga_out.vcount", vga_out.vcount, want.vcount);
                check_value("vga_out.hsync", vga_out.hsync, want.hsync);
                check_value("vga_out.vsync", vga_out.vsync, want.vsync);
                check_value("vga_out.hblnk", vga_out.hblnk, want.hblnk);
                check_value("vga_out.vblnk", vga_out.vblnk, want.vblnk);
                check_value("vga_out.rgb", vga_out.rgb, want.rgb);
        endtask

        initial begin : watchdog
                wait (table_len > 0);
                #((table_len + 20) * CLK_PERIOD);
                $display("[ERROR] %0t ns: the run did not finish in time", $time);
                $display("TEST FAILED");
                $fatal(1, "watchdog timeout");
        end

        initial begin : stimulus
                stim_t             e;
                vga_pkg::vga_bus_t want;
                int                i;
                clk        = 1'b0;
                rst        = 1'b1;
                vga_in     = '0;
                white_win  = 1'b0;
                black_win  = 1'b0;
                lfsr_state = LFSR_SEED;
                load_shape();
                build_table();
                table_len = stim_table.size();

                // Busy inputs while in reset must not reach the output
                @(posedge clk);
                #1;
                vga_in    = {11'd400, 11'd300, 4'hf, 12'habc};
                white_win = 1'b1;
                repeat (3) @(posedge clk);
                #1;
                expect_output('0);
                rst = 1'b0;

                for (i = 0; i < table_len; i++) begin
                        // Pipeline still holds reset values for two cycles
                        if (exp_q.size() == 2) begin
                                want = exp_q.pop_front();
                                expect_output(want);
                        end else begin
                                expect_output('0);
                        end
                        e         = stim_table[i];
                        vga_in    = e.bus;
                        white_win = e.white;
                        black_win = e.black;
                        want      = e.bus;
                        want.rgb  = e.exp_rgb;
                        exp_q.push_back(want);
                        @(posedge clk);
                        #1;
                end

                vga_in    = '0;
                white_win = 1'b0;
                black_win = 1'b0;
                repeat (2) begin
                        want = exp_q.pop_front();
                        expect_output(want);
                        @(posedge clk);
                        #1;
                end

                $display("TEST PASSED");
                $finish;
        end

endmodule

`default_nettype wire

//--- sim.f
+incdir+rtl
rtl/vga_pkg.sv
rtl/king_cell_locator.sv
rtl/king_shape_rom.sv
rtl/win_colorizer.sv
rtl/draw_win.sv
verification/tb_draw_win.sv

//--- Bender.yml
package:
  name: draw_win

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vga_pkg.sv
      - rtl/king_cell_locator.sv
      - rtl/king_shape_rom.sv
      - rtl/win_colorizer.sv
      - rtl/draw_win.sv

  - target: simulation
    include_dirs:
      - rtl
    files:
      - verification/tb_draw_win.sv
